// ==== vlog.f ====
+incdir+hw
hw/requant_pkg.sv
hw/rne_round.sv
hw/sat_narrow.sv
hw/requant_pipe.sv
hw/requant_status.sv
hw/requant_top.sv
dv/requant_tb.sv

// ==== Makefile ====
TOP := requant_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f vlog.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/requant_tb.sv ====
`timescale 1ns/1ps
`include "requant_params.svh"

module requant_tb;

	import requant_pkg::*;

	// Directed cases stay well under this many cycles each, drain included
	localparam int N_RANDOM    = 200;
	localparam int STIM_CYCLES = N_RANDOM + 6 * 24 + 4;
	localparam int TIMEOUT     = STIM_CYCLES + 200;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	sample_t    in_sample;
	scale_t     in_scale;
	logic       stat_clear;
	logic       out_valid;
	sample_t    out_sample;
	stat_kind_e out_kind;
	logic       ovf_sticky;
	logic       sat_sticky;
	evt_cnt_t   evt_count;

	// Scoreboard, one entry per accepted sample
	sample_t    exp_sample_q[$];
	stat_kind_e exp_kind_q[$];
	int         exp_acc_q[$];

	// Expected status block contents
	logic       exp_ovf;
	logic       exp_sat;
	evt_cnt_t   exp_cnt;

	int         cycle;
	int         errors;
	int         n_checks;
	logic [31:0] rand_state;

	// Monitor scratch
	sample_t    mon_sample;
	stat_kind_e mon_kind;
	int         mon_acc;

	requant_top u_requant_top
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_scale   (in_scale),
		.stat_clear (stat_clear),
		.out_valid  (out_valid),
		.out_sample (out_sample),
		.out_kind   (out_kind),
		.ovf_sticky (ovf_sticky),
		.sat_sticky (sat_sticky),
		.evt_count  (evt_count)
	);

	always #4 clk = ~clk;

	// Posedge count, also the run limit
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT)
		begin
			$display("Run timed out after %0d cycles, results still pending", cycle);
			$display("TEST FAIL");
			$finish;
		end
	end

	// **************************************************
	// Reference model and stimulus helpers
	// **************************************************

	// Product, round half to even, positive pin on wrap, shift, clamp
	function automatic void ref_result(input sample_t s, input scale_t c,
		output sample_t o, output stat_kind_e k);
		longint p;
		longint q;
		longint rem;
		longint half;
		longint prod_hi;
		longint samp_hi;
		longint samp_lo;
		p       = longint'(s) * longint'(c);
		half    = longint'(1) << (`REQ_DROP_BITS - 1);
		prod_hi = (longint'(1) << (`REQ_SAMPLE_W + `REQ_SCALE_W - 1)) - 1;
		samp_hi = (longint'(1) << (`REQ_SAMPLE_W - 1)) - 1;
		samp_lo = -(longint'(1) << (`REQ_SAMPLE_W - 1));
		// Floor quotient and a remainder that is never negative
		q   = p >>> `REQ_DROP_BITS;
		rem = p - (q << `REQ_DROP_BITS);
		if (rem > half || (rem == half && q[0]))
			q = q + 1;
		if ((q << `REQ_DROP_BITS) > prod_hi)
		begin
			o = sample_t'(samp_hi);
			k = ROUND_OVF;
		end
		else if (q > samp_hi)
		begin
			o = sample_t'(samp_hi);
			k = SATURATED;
		end
		else if (q < samp_lo)
		begin
			o = sample_t'(samp_lo);
			k = SATURATED;
		end
		else
		begin
			o = sample_t'(q);
			k = NORMAL;
		end
	endfunction

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One sample per falling edge, back to back when called in a row
	task automatic send(input sample_t s, input scale_t c);
		sample_t    es;
		stat_kind_e ek;
		@(negedge clk);
		in_valid  = 1'b1;
		in_sample = s;
		in_scale  = c;
		ref_result(s, c, es, ek);
		exp_sample_q.push_back(es);
		exp_kind_q.push_back(ek);
		// Cycle in which in_valid is high
		exp_acc_q.push_back(cycle);
		if (ek == ROUND_OVF)
			exp_ovf = 1'b1;
		if (ek == SATURATED)
			exp_sat = 1'b1;
		if (ek != NORMAL && exp_cnt != '1)
			exp_cnt = exp_cnt + evt_cnt_t'(1);
	endtask

	// Stop input, wait out the pipe, then one edge for the status block
	task automatic drain();
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_sample_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic clear_status();
		@(negedge clk);
		stat_clear = 1'b1;
		@(negedge clk);
		stat_clear = 1'b0;
		exp_ovf = 1'b0;
		exp_sat = 1'b0;
		exp_cnt = '0;
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before)
			$display("%-22s ok", name);
		else
			$display("%-22s %0d errors", name, errors - err_before);
	endtask

	// **************************************************
	// Compare tasks
	// **************************************************

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL @ %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_kind(input stat_kind_e got, input stat_kind_e exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL @ %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL @ %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input evt_cnt_t got, input evt_cnt_t exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL @ %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// Outputs settle after the rising edge, so look on the falling one
	always @(negedge clk)
	begin
		if (rst_n && out_valid)
		begin
			if (exp_sample_q.size() == 0)
			begin
				errors++;
				$display("Result came out at %0t with no sample waiting for it", $time);
			end
			else
			begin
				mon_sample = exp_sample_q.pop_front();
				mon_kind   = exp_kind_q.pop_front();
				mon_acc    = exp_acc_q.pop_front();
				check_sample(out_sample, mon_sample, "out_sample");
				check_kind(out_kind, mon_kind, "out_kind");
				// out_valid high three cycles after in_valid was
				n_checks++;
				if (cycle - mon_acc != 3)
				begin
					errors++;
					$display("FAIL @ %0t: result latency %0d cycles expected 3",
						$time, cycle - mon_acc);
				end
			end
		end
	end

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin : main
		int         e0;
		logic [31:0] r;
		scale_t     sc;
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_sample  = '0;
		in_scale   = '0;
		stat_clear = 1'b0;
		cycle      = 0;
		errors     = 0;
		n_checks   = 0;
		exp_ovf    = 1'b0;
		exp_sat    = 1'b0;
		exp_cnt    = '0;
		rand_state = 32'd16;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_kind(out_kind, NORMAL, "out_kind after reset");
		check_count(evt_count, '0, "evt_count after reset");

		// Scale of one in the output format passes samples through
		e0 = errors;
		send(16'sd0, 16'sd4096);
		send(16'sd1, 16'sd4096);
		send(-16'sd1, 16'sd4096);
		send(16'sd1234, 16'sd4096);
		send(-16'sd32768, 16'sd4096);
		send(16'sd32767, 16'sd4096);
		drain();
		check_count(evt_count, exp_cnt, "evt_count after exact products");
		end_test("exact_passthrough", e0);

		// Scale of one leaves the product equal to the sample
		e0 = errors;
		send(16'sh0800, 16'sd1);
		send(16'sh1800, 16'sd1);
		send(16'sh0801, 16'sd1);
		send(16'sh07FF, 16'sd1);
		send(16'sh1801, 16'sd1);
		send(16'sh17FF, 16'sd1);
		send(-16'sd2048, 16'sd1);
		send(-16'sd6144, 16'sd1);
		drain();
		end_test("ties_to_even", e0);

		e0 = errors;
		send(16'sd30000, 16'sd30000);
		send(-16'sd30000, 16'sd30000);
		drain();
		check_flag(sat_sticky, exp_sat, "sat_sticky");
		check_count(evt_count, exp_cnt, "evt_count after clamps");
		end_test("saturation", e0);

		// Largest magnitudes the operands allow
		e0 = errors;
		send(16'sd32767, 16'sd32767);
		send(-16'sd32768, -16'sd32768);
		drain();
		check_sample(out_sample, 16'sd32767, "out_sample at top");
		check_flag(ovf_sticky, exp_ovf, "ovf_sticky");
		check_flag(sat_sticky, exp_sat, "sat_sticky");
		end_test("top_of_range", e0);

		e0 = errors;
		clear_status();
		for (int i = 0; i < N_RANDOM; i++)
		begin
			rand_state = next_rand(rand_state);
			r  = rand_state;
			// Shrink some scales so not every product clamps
			sc = scale_t'(r[31:16]);
			sc = sc >>> r[3:1];
			send(sample_t'(r[15:0]), sc);
		end
		drain();
		check_flag(ovf_sticky, exp_ovf, "ovf_sticky after random");
		check_flag(sat_sticky, exp_sat, "sat_sticky after random");
		check_count(evt_count, exp_cnt, "evt_count after random");
		end_test("random_back_to_back", e0);

		e0 = errors;
		clear_status();
		check_flag(ovf_sticky, 1'b0, "ovf_sticky after clear");
		check_flag(sat_sticky, 1'b0, "sat_sticky after clear");
		check_count(evt_count, '0, "evt_count after clear");
		send(16'sd20000, -16'sd20000);
		drain();
		check_count(evt_count, evt_cnt_t'(1), "evt_count first event after clear");
		check_flag(sat_sticky, 1'b1, "sat_sticky first event after clear");
		end_test("status_clear", e0);

		$display("checks %0d, errors %0d", n_checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== hw/requant_top.sv ====
`timescale 1ns/1ps

module requant_top
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  requant_pkg::sample_t    in_sample,
	input  requant_pkg::scale_t     in_scale,
	input  logic                    stat_clear,
	output logic                    out_valid,
	output requant_pkg::sample_t    out_sample,
	output requant_pkg::stat_kind_e out_kind,
	output logic                    ovf_sticky,
	output logic                    sat_sticky,
	output requant_pkg::evt_cnt_t   evt_count
);

	// ************************************************
	// Datapath
	// ************************************************

	// Multiply, round, narrow in three registered stages
	requant_pipe u_pipe
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_scale   (in_scale),
		.out_valid  (out_valid),
		.out_sample (out_sample),
		.out_kind   (out_kind)
	);

	// ************************************************
	// Status
	// ************************************************

	// Watches the same result strobe that leaves the block
	requant_status u_status
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.event_valid (out_valid),
		.event_kind  (out_kind),
		.stat_clear  (stat_clear),
		.ovf_sticky  (ovf_sticky),
		.sat_sticky  (sat_sticky),
		.evt_count   (evt_count)
	);

endmodule

// ==== hw/requant_status.sv ====
`timescale 1ns/1ps

module requant_status
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    event_valid,
	input  requant_pkg::stat_kind_e event_kind,
	input  logic                    stat_clear,
	output logic                    ovf_sticky,
	output logic                    sat_sticky,
	output requant_pkg::evt_cnt_t   evt_count
);

	import requant_pkg::*;

	logic hit_ovf;
	logic hit_sat;
	logic hit_any;
	logic cnt_full;

	// ************************************************
	// Event decode
	// ************************************************

	assign hit_ovf = event_valid && (event_kind == ROUND_OVF);
	assign hit_sat = event_valid && (event_kind == SATURATED);

	// Every result that was not clean counts once
	assign hit_any = event_valid && (event_kind != NORMAL);

	// Counter stops here instead of wrapping to zero
	assign cnt_full = (evt_count == '1);

	// ************************************************
	// Sticky flags and counter
	// ************************************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ovf_sticky <= 1'b0;
			sat_sticky <= 1'b0;
			evt_count  <= '0;
		end
		else if (stat_clear)
		begin
			// Clear wins, an event on the same edge is lost
			ovf_sticky <= 1'b0;
			sat_sticky <= 1'b0;
			evt_count  <= '0;
		end
		else
		begin
			if (hit_ovf)
				ovf_sticky <= 1'b1;
			if (hit_sat)
				sat_sticky <= 1'b1;
			if (hit_any && !cnt_full)
				evt_count <= evt_count + evt_cnt_t'(1);
		end
	end

	// A raised flag always comes with at least one counted event
	assert property (@(posedge clk) disable iff (!rst_n)
		(ovf_sticky || sat_sticky) |-> (evt_count != '0))
		else $error("requant_status: sticky flag set with a zero counter");

endmodule

// ==== hw/requant_pipe.sv ====
`timescale 1ns/1ps
`include "requant_params.svh"

module requant_pipe
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  requant_pkg::sample_t    in_sample,
	input  requant_pkg::scale_t     in_scale,
	output logic                    out_valid,
	output requant_pkg::sample_t    out_sample,
	output requant_pkg::stat_kind_e out_kind
);

	import requant_pkg::*;

	// Stage 1, full product
	logic       s1_valid;
	product_t   s1_prod;

	// Stage 2, rounded product and its wrap flag
	logic       s2_valid;
	product_t   s2_rnd;
	logic       s2_ovf;

	// Combinational results between the stages
	product_t   rnd_value;
	logic       rnd_ovf;
	sample_t    narrow_sample;
	logic       narrow_sat;
	sample_t    sample_next;
	stat_kind_e kind_next;

	// ************************************************
	// Valid shift
	// ************************************************

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
			out_kind  <= NORMAL;
		end
		else
		begin
			s1_valid  <= in_valid;
			s2_valid  <= s1_valid;
			out_valid <= s2_valid;
			// Kind holds until the next result
			if (s2_valid)
				out_kind <= kind_next;
		end
	end

	// ************************************************
	// Stage 1, multiply
	// ************************************************

	// Both operands sign extended to the product width first
	always_ff @(posedge clk)
	begin
		if (in_valid)
			s1_prod <= product_t'(in_sample) * product_t'(in_scale);
	end

	// ************************************************
	// Stage 2, round half to even
	// ************************************************

	rne_round
	#(
		.WIDTH       ($bits(product_t)),
		.DROP        (`REQ_DROP_BITS),
		.IS_UNSIGNED (1'b0)
	)
	u_rne_round
	(
		.value_in  (s1_prod),
		.value_out (rnd_value),
		.overflow  (rnd_ovf)
	);

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			s2_rnd <= rnd_value;
			s2_ovf <= rnd_ovf;
		end
	end

	// ************************************************
	// Stage 3, narrow and classify
	// ************************************************

	sat_narrow u_sat_narrow
	(
		.prod_in    (s2_rnd),
		.sample_out (narrow_sample),
		.saturated  (narrow_sat)
	);

	// A wrapped round came from a positive value, so pin it high
	always_comb
	begin
		if (s2_ovf)
		begin
			sample_next = SAMPLE_MAX;
			kind_next   = ROUND_OVF;
		end
		else
		begin
			sample_next = narrow_sample;
			kind_next   = narrow_sat ? SATURATED : NORMAL;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid)
			out_sample <= sample_next;
	end

	// Output strobe never unknown once out of reset
	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
		else $error("requant_pipe: out_valid is unknown");

	// Every accepted sample leaves three edges later
	assert property (@(posedge clk) disable iff (!rst_n) $past(in_valid, 3) |-> out_valid)
		else $error("requant_pipe: result missing three cycles after input");

endmodule

// ==== hw/sat_narrow.sv ====
`timescale 1ns/1ps
`include "requant_params.svh"

module sat_narrow
(
	input  requant_pkg::product_t prod_in,
	output requant_pkg::sample_t  sample_out,
	output logic                  saturated
);

	import requant_pkg::*;

	localparam int PROD_W = $bits(product_t);
	localparam int SAMP_W = `REQ_SAMPLE_W;

	product_t               shifted;
	logic [PROD_W-SAMP_W:0] upper_bits;
	logic                   fits;

	// ************************************************
	// Scale down
	// ************************************************

	// Arithmetic shift keeps the sign of the product
	// Rounding already cleared the bits shifted out
	assign shifted = prod_in >>> `REQ_DROP_BITS;

	// ************************************************
	// Range check and clamp
	// ************************************************

	// Sample sign bit and everything above it
	assign upper_bits = shifted[PROD_W-1:SAMP_W-1];

	// Value fits when all those bits repeat the sign
	assign fits = (upper_bits == '0) || (upper_bits == '1);

	always_comb
	begin
		if (fits)
		begin
			sample_out = shifted[SAMP_W-1:0];
			saturated  = 1'b0;
		end
		else if (shifted[PROD_W-1])
		begin
			// Below the range
			sample_out = SAMPLE_MIN;
			saturated  = 1'b1;
		end
		else
		begin
			// Above the range
			sample_out = SAMPLE_MAX;
			saturated  = 1'b1;
		end
	end

endmodule

// ==== hw/rne_round.sv ====
`timescale 1ns/1ps

module rne_round
#(
	parameter int WIDTH       = 32,
	parameter int DROP        = 12,
	parameter bit IS_UNSIGNED = 1'b0
)
(
	input  logic [WIDTH-1:0] value_in,
	output logic [WIDTH-1:0] value_out,
	output logic             overflow
);

	// ************************************************
	// Split into kept and dropped parts
	// ************************************************

	// One extra bit on top so the carry of the round-up is not lost
	localparam int EXT_W  = WIDTH + 1;
	localparam int KEEP_W = EXT_W - DROP;

	// Half of one kept LSB, at the input scale
	localparam logic [EXT_W-1:0] HALF_STEP = EXT_W'(1) << (DROP - 1);

	logic [EXT_W-1:0]  value_ext;
	logic [KEEP_W-1:0] kept;
	logic [DROP-1:0]   dropped;
	logic              half_bit;
	logic              sticky_bits;
	logic              round_up;
	logic [KEEP_W-1:0] kept_rnd;
	logic [EXT_W-1:0]  result_ext;
	logic [EXT_W-1:0]  round_dist;

	// Sign extension in signed mode, zero extension otherwise
	assign value_ext = {(IS_UNSIGNED ? 1'b0 : value_in[WIDTH-1]), value_in};

	assign {kept, dropped} = value_ext;

	// First dropped bit is worth exactly one half of the kept LSB
	assign half_bit = dropped[DROP-1];

	// Anything below the half bit, needs DROP of at least 2
	assign sticky_bits = |dropped[DROP-2:0];

	// ************************************************
	// Round half to even
	// ************************************************

	// Above half always rounds up
	// Exact half rounds up only to make the kept LSB even
	assign round_up = half_bit & (sticky_bits | kept[0]);

	assign kept_rnd = kept + KEEP_W'(round_up);

	// Dropped bits cleared, value stays at the input scale
	assign result_ext = {kept_rnd, {DROP{1'b0}}};
	assign value_out  = result_ext[WIDTH-1:0];

	// ************************************************
	// Overflow
	// ************************************************

	always_comb
	begin
		if (IS_UNSIGNED)
			// Carry out of the top bit
			overflow = result_ext[WIDTH];
		else
			// Only a positive value can wrap, its sign turns negative
			overflow = ~value_ext[WIDTH] & result_ext[WIDTH-1];
	end

	// Distance moved by rounding, offset so the allowed range starts at zero
	assign round_dist = result_ext - value_ext + HALF_STEP;

	// Rounding moves the value by half a drop step at most
	always_comb
	begin
		assert (round_dist <= (HALF_STEP << 1))
			else $error("rne_round: value moved by more than half a step");
	end

endmodule

// ==== hw/requant_pkg.sv ====
`include "requant_params.svh"

package requant_pkg;

	// Signed sample, used on the input and on the narrowed output
	typedef logic signed [`REQ_SAMPLE_W-1:0] sample_t;

	// Signed scale factor
	typedef logic signed [`REQ_SCALE_W-1:0] scale_t;

	// Full precision product of sample and scale
	typedef logic signed [`REQ_SAMPLE_W+`REQ_SCALE_W-1:0] product_t;

	// Count of results that were not clean
	typedef logic [`REQ_CNT_W-1:0] evt_cnt_t;

	// Kind of each result leaving the pipeline
	typedef enum logic [1:0] {
		NORMAL    = 2'd0,
		ROUND_OVF = 2'd1,
		SATURATED = 2'd2
	} stat_kind_e;

	// Clamp limits of the output range
	localparam sample_t SAMPLE_MAX = {1'b0, {(`REQ_SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(`REQ_SAMPLE_W-1){1'b0}}};

endpackage

// ==== hw/requant_params.svh ====
`ifndef REQUANT_PARAMS_SVH
`define REQUANT_PARAMS_SVH

// ************************************************
// Datapath widths
// ************************************************

// Input sample and narrowed output sample
`define REQ_SAMPLE_W 16

// Signed scale operand
`define REQ_SCALE_W 16

// ************************************************
// Requantization point and status
// ************************************************

// Low product bits rounded away, same amount as the final right shift
`define REQ_DROP_BITS 12

// Event counter width, counter sticks at all ones
`define REQ_CNT_W 16

`endif
